// File: rtl/trace_pkg.sv
package trace_pkg;

   // Lane counts
   localparam int issue_width  = 2;
   localparam int commit_width = 2;

   // Shadow ROB geometry with one bank per commit lane
   localparam int bank_bits      = 1;
   localparam int rob_depth_bits = 3;
   localparam int rob_depth      = 1 << rob_depth_bits;
   localparam int push_size_bits = $clog2(issue_width + 1);

   localparam int num_irq = 8;

   // Trace memory
   localparam int trace_depth_bits = 6;
   localparam int trace_depth      = 1 << trace_depth_bits;

   // Writers are lane 0, lane 1 and irq
   localparam int num_writers = 3;
   localparam int writer_bits = $clog2(num_writers);
   localparam int irq_writer  = num_writers - 1;

   typedef logic [31:0]                 insn_t;
   // Word address whose byte address is {pc, 2'b00}
   typedef logic [29:0]                 pc_t;
   typedef logic [4:0]                  lrf_addr_t;
   typedef logic [31:0]                 data_t;
   typedef logic [rob_depth_bits-1:0]   rob_id_t;
   typedef logic [bank_bits-1:0]        bank_t;
   typedef logic [num_irq-1:0]          irq_vec_t;
   typedef logic [trace_depth_bits-1:0] trace_addr_t;
   typedef logic [15:0]                 cnt_t;

   typedef enum logic {
      rec_commit = 1'b0,
      rec_irq    = 1'b1
   } rec_kind_t;

   typedef struct packed {
      rec_kind_t kind;
      logic      lane;
      logic      excp;
      logic      we;
      lrf_addr_t waddr;
      pc_t       pc;
      insn_t     insn;
      data_t     wdata;
      irq_vec_t  irr;
   } trace_rec_t;

   typedef struct packed {
      logic      fire;
      logic      excp;
      pc_t       pc;
      logic      we;
      lrf_addr_t waddr;
      data_t     wdata;
   } commit_lane_t;

   typedef struct packed {
      bank_t   bank;
      rob_id_t id;
   } rob_push_t;

endpackage

// File: rtl/shadow_rob_insn.sv
`timescale 1ns/1ps

module shadow_rob_insn
(
   input  logic                                                  clk,
   input  logic                                                  rst,
   input  trace_pkg::insn_t [trace_pkg::issue_width-1:0]         id_ins,
   input  logic                                                  id_load,
   input  logic                                                  rn_load,
   input  trace_pkg::rob_push_t [trace_pkg::issue_width-1:0]     push,
   input  logic [trace_pkg::push_size_bits-1:0]                  push_size,
   input  trace_pkg::bank_t [trace_pkg::commit_width-1:0]        head_bank,
   input  trace_pkg::rob_id_t [trace_pkg::commit_width-1:0]      que_rptr,
   output trace_pkg::insn_t [trace_pkg::commit_width-1:0]        cmt_insn
);

   localparam int num_banks = 1 << trace_pkg::bank_bits;

   // Decode group delayed to line up with the ROB push
   trace_pkg::insn_t [trace_pkg::issue_width-1:0] rn_ins;
   trace_pkg::insn_t [trace_pkg::issue_width-1:0] iss_ins;

   // Instruction words kept alongside the core's ROB entries
   trace_pkg::insn_t rob_mem [num_banks][trace_pkg::rob_depth];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rn_ins  <= '0;
         iss_ins <= '0;
      end
      else
      begin
         if (id_load)
         begin
            rn_ins <= id_ins;
         end
         if (rn_load)
         begin
            iss_ins <= rn_ins;
         end
      end
   end

   // Only slots below push_size carry a real instruction
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         for (int i = 0; i < trace_pkg::issue_width; i++)
         begin
            if (i < int'(push_size))
            begin
               rob_mem[push[i].bank][push[i].id] <= iss_ins[i];
            end
         end
      end
   end

   // Head entry of each lane read through that bank's pointer
   always_comb
   begin
      for (int l = 0; l < trace_pkg::commit_width; l++)
      begin
         cmt_insn[l] = rob_mem[head_bank[l]][que_rptr[head_bank[l]]];
      end
   end

endmodule

// File: rtl/commit_capture.sv
`timescale 1ns/1ps

module commit_capture
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    lane_id,
   input  trace_pkg::commit_lane_t cmt,
   input  logic                    excp_flush,
   input  trace_pkg::insn_t        insn,
   input  logic                    grant,
   output logic                    pending,
   output trace_pkg::trace_rec_t   rec,
   output trace_pkg::cnt_t         drops
);

   trace_pkg::trace_rec_t new_rec;
   logic                  slot_free;

   // A slot being granted this cycle can take the next record
   assign slot_free = !pending || grant;

   always_comb
   begin
      new_rec       = '0;
      new_rec.kind  = trace_pkg::rec_commit;
      new_rec.lane  = lane_id;
      // Flush is reported on lane 0 only
      new_rec.excp  = cmt.excp || (excp_flush && lane_id == 1'b0);
      new_rec.we    = cmt.we;
      new_rec.waddr = cmt.waddr;
      new_rec.pc    = cmt.pc;
      new_rec.insn  = insn;
      new_rec.wdata = cmt.wdata;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pending <= 1'b0;
         drops   <= '0;
      end
      else
      begin
         if (grant)
         begin
            pending <= 1'b0;
         end
         if (cmt.fire)
         begin
            if (slot_free)
            begin
               pending <= 1'b1;
            end
            else
            begin
               drops <= drops + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmt.fire && slot_free)
      begin
         rec <= new_rec;
      end
   end

endmodule

// File: rtl/irq_event_capture.sv
`timescale 1ns/1ps

module irq_event_capture
(
   input  logic                  clk,
   input  logic                  rst,
   input  trace_pkg::irq_vec_t   irr,
   input  logic                  grant,
   output logic                  pending,
   output trace_pkg::trace_rec_t rec,
   output trace_pkg::cnt_t       drops
);

   trace_pkg::irq_vec_t irr_prev;
   logic                changed;
   logic                slot_free;

   assign changed   = irr != irr_prev;
   assign slot_free = !pending || grant;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         irr_prev <= '0;
         pending  <= 1'b0;
         drops    <= '0;
      end
      else
      begin
         irr_prev <= irr;
         if (grant)
         begin
            pending <= 1'b0;
         end
         if (changed)
         begin
            if (slot_free)
            begin
               pending <= 1'b1;
            end
            else
            begin
               drops <= drops + 1'b1;
            end
         end
      end
   end

   // Irq record carries only the new vector
   always_ff @(posedge clk)
   begin
      if (changed && slot_free)
      begin
         rec      <= '0;
         rec.kind <= trace_pkg::rec_irq;
         rec.irr  <= irr;
      end
   end

endmodule

// File: rtl/trace_arbiter.sv
`timescale 1ns/1ps

module trace_arbiter
(
   input  logic                                                 clk,
   input  logic                                                 rst,
   input  logic [trace_pkg::num_writers-1:0]                    req,
   input  trace_pkg::trace_rec_t [trace_pkg::num_writers-1:0]   rec_in,
   output logic [trace_pkg::num_writers-1:0]                    grant,
   output logic                                                 wr_en,
   output trace_pkg::trace_rec_t                                wr_rec
);

   // Writer with the highest priority next
   logic [trace_pkg::writer_bits-1:0] rr_ptr;
   logic [trace_pkg::writer_bits-1:0] win;
   logic                              found;

   always_comb
   begin
      int idx;
      grant = '0;
      win   = rr_ptr;
      found = 1'b0;
      for (int k = 0; k < trace_pkg::num_writers; k++)
      begin
         idx = (int'(rr_ptr) + k) % trace_pkg::num_writers;
         if (req[idx] && !found)
         begin
            grant[idx] = 1'b1;
            win        = trace_pkg::writer_bits'(idx);
            found      = 1'b1;
         end
      end
   end

   assign wr_en  = found;
   assign wr_rec = rec_in[win];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rr_ptr <= '0;
      end
      else if (found)
      begin
         // Step past the winner
         if (win == trace_pkg::writer_bits'(trace_pkg::num_writers - 1))
         begin
            rr_ptr <= '0;
         end
         else
         begin
            rr_ptr <= win + 1'b1;
         end
      end
   end

endmodule

// File: rtl/trace_buffer.sv
`timescale 1ns/1ps

module trace_buffer
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wr_en,
   input  trace_pkg::trace_rec_t wr_rec,
   input  trace_pkg::trace_addr_t rd_addr,
   output trace_pkg::trace_rec_t rd_rec,
   output trace_pkg::cnt_t       count,
   output logic                  full,
   output trace_pkg::cnt_t       refused
);

   trace_pkg::trace_rec_t  mem [trace_pkg::trace_depth];
   trace_pkg::trace_addr_t wr_ptr;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr  <= '0;
         count   <= '0;
         full    <= 1'b0;
         refused <= '0;
      end
      else if (wr_en)
      begin
         if (full)
         begin
            // No wrap so the record is lost
            refused <= refused + 1'b1;
         end
         else
         begin
            wr_ptr <= wr_ptr + 1'b1;
            count  <= count + 1'b1;
            full   <= count == trace_pkg::cnt_t'(trace_pkg::trace_depth - 1);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en && !full)
      begin
         mem[wr_ptr] <= wr_rec;
      end
      rd_rec <= mem[rd_addr];
   end

endmodule

// File: rtl/commit_trace_top.sv
`timescale 1ns/1ps

module commit_trace_top
(
   input  logic                                                clk,
   input  logic                                                rst,
   input  trace_pkg::insn_t [trace_pkg::issue_width-1:0]       id_ins,
   input  logic                                                id_load,
   input  logic                                                rn_load,
   input  trace_pkg::rob_push_t [trace_pkg::issue_width-1:0]   push,
   input  logic [trace_pkg::push_size_bits-1:0]                push_size,
   input  trace_pkg::bank_t [trace_pkg::commit_width-1:0]      head_bank,
   input  trace_pkg::rob_id_t [trace_pkg::commit_width-1:0]    que_rptr,
   input  trace_pkg::commit_lane_t [trace_pkg::commit_width-1:0] cmt,
   input  logic                                                excp_flush,
   input  trace_pkg::irq_vec_t                                 irr,
   input  trace_pkg::trace_addr_t                              rd_addr,
   output trace_pkg::trace_rec_t                               rd_rec,
   output trace_pkg::cnt_t                                     count,
   output logic                                                full,
   output trace_pkg::cnt_t [trace_pkg::num_writers-1:0]        drops,
   output trace_pkg::cnt_t                                     refused
);

   trace_pkg::insn_t [trace_pkg::commit_width-1:0]      cmt_insn;
   logic [trace_pkg::num_writers-1:0]                   req;
   logic [trace_pkg::num_writers-1:0]                   grant;
   trace_pkg::trace_rec_t [trace_pkg::num_writers-1:0]  recs;
   logic                                                wr_en;
   trace_pkg::trace_rec_t                               wr_rec;

   shadow_rob_insn u_shadow_rob (
      .clk       (clk),
      .rst       (rst),
      .id_ins    (id_ins),
      .id_load   (id_load),
      .rn_load   (rn_load),
      .push      (push),
      .push_size (push_size),
      .head_bank (head_bank),
      .que_rptr  (que_rptr),
      .cmt_insn  (cmt_insn)
   );

   // Writers 0 and 1 are the commit lanes
   for (genvar l = 0; l < trace_pkg::commit_width; l++)
   begin : g_lane
      commit_capture u_capture (
         .clk        (clk),
         .rst        (rst),
         .lane_id    (1'(l)),
         .cmt        (cmt[l]),
         .excp_flush (excp_flush),
         .insn       (cmt_insn[l]),
         .grant      (grant[l]),
         .pending    (req[l]),
         .rec        (recs[l]),
         .drops      (drops[l])
      );
   end

   irq_event_capture u_irq_capture (
      .clk     (clk),
      .rst     (rst),
      .irr     (irr),
      .grant   (grant[trace_pkg::irq_writer]),
      .pending (req[trace_pkg::irq_writer]),
      .rec     (recs[trace_pkg::irq_writer]),
      .drops   (drops[trace_pkg::irq_writer])
   );

   trace_arbiter u_arbiter (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .rec_in (recs),
      .grant  (grant),
      .wr_en  (wr_en),
      .wr_rec (wr_rec)
   );

   trace_buffer u_buffer (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (wr_en),
      .wr_rec  (wr_rec),
      .rd_addr (rd_addr),
      .rd_rec  (rd_rec),
      .count   (count),
      .full    (full),
      .refused (refused)
   );

endmodule

// File: testbench/commit_trace_tb.sv
`timescale 1ns/1ps

module commit_trace_tb;

   localparam int settle_limit = 32;

   logic                                                  clk;
   logic                                                  rst;
   trace_pkg::insn_t [trace_pkg::issue_width-1:0]         id_ins;
   logic                                                  id_load;
   logic                                                  rn_load;
   trace_pkg::rob_push_t [trace_pkg::issue_width-1:0]     push;
   logic [trace_pkg::push_size_bits-1:0]                  push_size;
   trace_pkg::bank_t [trace_pkg::commit_width-1:0]        head_bank;
   trace_pkg::rob_id_t [trace_pkg::commit_width-1:0]      que_rptr;
   trace_pkg::commit_lane_t [trace_pkg::commit_width-1:0] cmt;
   logic                                                  excp_flush;
   trace_pkg::irq_vec_t                                   irr;
   trace_pkg::trace_addr_t                                rd_addr;
   trace_pkg::trace_rec_t                                 rd_rec;
   trace_pkg::cnt_t                                       count;
   logic                                                  full;
   trace_pkg::cnt_t [trace_pkg::num_writers-1:0]          drops;
   trace_pkg::cnt_t                                       refused;

   // Reference model of the decode path and the expected records per writer
   trace_pkg::insn_t [trace_pkg::issue_width-1:0] mdl_rn;
   trace_pkg::insn_t [trace_pkg::issue_width-1:0] mdl_iss;
   trace_pkg::insn_t                              mdl_rob [2][trace_pkg::rob_depth];
   trace_pkg::irq_vec_t                           mdl_irr;
   trace_pkg::trace_rec_t                         exp_q [trace_pkg::num_writers][$];
   string                                         stim [$];
   integer                                        seed = 34764;
   int                                            val_errors;
   int                                            other_errors;

   commit_trace_top dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_rec(input trace_pkg::trace_rec_t got, input trace_pkg::trace_rec_t exp,
                            input string msg);
      if (got !== exp)
      begin
         val_errors++;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_count(input trace_pkg::cnt_t got, input trace_pkg::cnt_t exp,
                              input string msg);
      if (got !== exp)
      begin
         val_errors++;
         $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      end
   endtask

   task automatic check_insn(input trace_pkg::insn_t got, input trace_pkg::insn_t exp,
                             input string msg);
      if (got !== exp)
      begin
         val_errors++;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   function automatic int total_drops();
      int sum;
      sum = 0;
      for (int i = 0; i < trace_pkg::num_writers; i++)
      begin
         sum += int'(drops[i]);
      end
      return sum;
   endfunction

   // Quiet inputs with random filler in the unused fields
   task automatic drive_idle();
      id_load    = 1'b0;
      rn_load    = 1'b0;
      push_size  = '0;
      excp_flush = 1'b0;
      for (int i = 0; i < trace_pkg::issue_width; i++)
      begin
         id_ins[i] = trace_pkg::insn_t'($random(seed));
      end
      for (int l = 0; l < trace_pkg::commit_width; l++)
      begin
         cmt[l].fire  = 1'b0;
         cmt[l].excp  = 1'($random(seed));
         cmt[l].pc    = trace_pkg::pc_t'($random(seed));
         cmt[l].we    = 1'($random(seed));
         cmt[l].waddr = trace_pkg::lrf_addr_t'($random(seed));
         cmt[l].wdata = trace_pkg::data_t'($random(seed));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
      drive_idle();
   endtask

   task automatic drive_commit(input int l, input logic flush, input trace_pkg::bank_t bank,
                               input trace_pkg::rob_id_t rptr);
      trace_pkg::trace_rec_t e;
      cmt[l].fire    = 1'b1;
      head_bank[l]   = bank;
      que_rptr[bank] = rptr;
      e              = '0;
      e.kind         = trace_pkg::rec_commit;
      e.lane         = 1'(l);
      // Flush shows up on lane 0 only
      e.excp         = cmt[l].excp || (flush && (l == 0));
      e.we           = cmt[l].we;
      e.waddr        = cmt[l].waddr;
      e.pc           = cmt[l].pc;
      e.insn         = mdl_rob[bank][rptr];
      e.wdata        = cmt[l].wdata;
      exp_q[l].push_back(e);
   endtask

   task automatic drive_irq(input trace_pkg::irq_vec_t v);
      trace_pkg::trace_rec_t e;
      irr = v;
      if (v != mdl_irr)
      begin
         e      = '0;
         e.kind = trace_pkg::rec_irq;
         e.irr  = v;
         exp_q[trace_pkg::irq_writer].push_back(e);
      end
      mdl_irr = v;
   endtask

   task automatic read_check(input logic full_exp);
      int  events;
      int  waited;
      int  n;
      int  w;
      bit  hit;
      int  pos [trace_pkg::num_writers];
      int  found [trace_pkg::num_writers];
      trace_pkg::trace_rec_t e;
      events = 0;
      waited = 0;
      for (int i = 0; i < trace_pkg::num_writers; i++)
      begin
         events  += exp_q[i].size();
         pos[i]   = 0;
         found[i] = 0;
      end
      // Done once every captured event has reached the buffer
      while (int'(count) + int'(refused) != events - total_drops() && waited < settle_limit)
      begin
         next_cycle();
         waited++;
      end
      if (int'(count) + int'(refused) != events - total_drops())
      begin
         other_errors++;
         $display("Trace count did not settle after the last event");
      end
      n = int'(count);
      for (int a = 0; a < n; a++)
      begin
         rd_addr = trace_pkg::trace_addr_t'(a);
         next_cycle();
         w   = (rd_rec.kind == trace_pkg::rec_irq) ? trace_pkg::irq_writer : int'(rd_rec.lane);
         hit = 1'b0;
         // Lost events are skipped and the rest follow in event order
         while (!hit && pos[w] < exp_q[w].size())
         begin
            e = exp_q[w][pos[w]];
            if (rd_rec.kind == e.kind && rd_rec.pc == e.pc && rd_rec.wdata == e.wdata &&
                rd_rec.irr == e.irr)
            begin
               check_insn(rd_rec.insn, e.insn, "instruction word in commit record");
               check_rec(rd_rec, e, "trace record");
               found[w]++;
               hit = 1'b1;
            end
            pos[w]++;
         end
         if (!hit)
         begin
            other_errors++;
            $display("Trace entry %0d matches no remaining event of writer %0d", a, w);
         end
      end
      if (full_exp)
      begin
         check_count(count, trace_pkg::cnt_t'(trace_pkg::trace_depth), "count of full buffer");
         check_count(refused, trace_pkg::cnt_t'(events - total_drops() - trace_pkg::trace_depth),
                     "refused records");
      end
      else
      begin
         for (int i = 0; i < trace_pkg::num_writers; i++)
         begin
            check_count(trace_pkg::cnt_t'(found[i]) + drops[i],
                        trace_pkg::cnt_t'(exp_q[i].size()), "records plus drops per writer");
         end
         check_count(refused, '0, "refused records");
      end
      check_count(trace_pkg::cnt_t'(full), trace_pkg::cnt_t'(full_exp), "full flag");
   endtask

   initial
   begin
      int          fd;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      logic [31:0] e;
      rst          = 1'b1;
      id_ins       = '0;
      push         = '0;
      head_bank    = '0;
      que_rptr     = '0;
      irr          = '0;
      rd_addr      = '0;
      mdl_rn       = '0;
      mdl_iss      = '0;
      mdl_irr      = '0;
      val_errors   = 0;
      other_errors = 0;
      a            = '0;
      b            = '0;
      c            = '0;
      d            = '0;
      e            = '0;
      drive_idle();
      fd = $fopen("testbench/commit_trace_stimulus.txt", "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("Cannot open testbench/commit_trace_stimulus.txt");
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
            begin
               stim.push_back(line);
            end
         end
         $fclose(fd);
      end
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (stim[i])
      begin
         op = stim[i].getc(0);
         void'($sscanf(stim[i].substr(1, stim[i].len() - 1), "%h %h %h %h %h", a, b, c, d, e));
         case (op)
            "I":
            begin
               next_cycle();
               id_ins[0] = a;
               id_ins[1] = b;
               id_load   = 1'b1;
               mdl_rn[0] = a;
               mdl_rn[1] = b;
            end
            "R":
            begin
               next_cycle();
               rn_load = 1'b1;
               mdl_iss = mdl_rn;
            end
            "P":
            begin
               next_cycle();
               push_size    = trace_pkg::push_size_bits'(a);
               push[0].bank = trace_pkg::bank_t'(b);
               push[0].id   = trace_pkg::rob_id_t'(c);
               push[1].bank = trace_pkg::bank_t'(d);
               push[1].id   = trace_pkg::rob_id_t'(e);
               for (int s = 0; s < int'(a); s++)
               begin
                  mdl_rob[push[s].bank][push[s].id] = mdl_iss[s];
               end
            end
            "C":
            begin
               next_cycle();
               excp_flush = b[0];
               for (int l = 0; l < trace_pkg::commit_width; l++)
               begin
                  if (a[l])
                  begin
                     // Lane exceptions stay low so only the flush marks a record
                     cmt[l].excp = 1'b0;
                     drive_commit(l, b[0], trace_pkg::bank_t'(l) ^ c[0],
                                  trace_pkg::rob_id_t'(l == 0 ? d : e));
                  end
               end
            end
            "Q":
            begin
               next_cycle();
               drive_irq(trace_pkg::irq_vec_t'(a));
            end
            "B":
            begin
               // Both lanes fire and the vector toggles every cycle
               for (int k = 0; k < int'(a); k++)
               begin
                  next_cycle();
                  drive_commit(0, 1'b0, 1'b0, trace_pkg::rob_id_t'(k & 1));
                  drive_commit(1, 1'b0, 1'b1, trace_pkg::rob_id_t'(k & 1));
                  drive_irq(~irr);
               end
            end
            "W":
            begin
               repeat (int'(a)) next_cycle();
            end
            "D":
            begin
               read_check(a[0]);
            end
            default:
            begin
               other_errors++;
               $display("Unknown stimulus operation in line: %s", stim[i]);
            end
         endcase
      end
      next_cycle();
      $display("Errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
      if (val_errors == 0 && other_errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // Watchdog sized from the stimulus length plus readout
   initial
   begin
      #1;
      repeat (stim.size() + trace_pkg::trace_depth + 200) @(posedge clk);
      $display("Timeout: the run did not end within the stimulus length plus readout margin");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: testbench/commit_trace_stimulus.txt
# op fields in hex: I w0 w1 | R | P size b0 i0 b1 i1 | C mask flush swap rptr0 rptr1
# Q irr | B cycles | W cycles | D full_expected (count, drops and refusals checked on readout)
I 00a00093 00b00113
R
P 2 0 0 1 0
I 00c00193 00d00213
R
P 2 0 1 1 1
I 00e00293 00f00313
R
P 1 1 2 0 0
W 2
C 1 0 0 0 0
Q 05
W 2
C 2 0 0 0 0
Q 05
W 2
C 3 1 0 1 1
Q a0
W 2
C 3 0 1 2 1
W 3
B c
W 4
D 0
B 38
W 4
D 1

// File: sources.f
rtl/trace_pkg.sv
rtl/shadow_rob_insn.sv
rtl/commit_capture.sv
rtl/irq_event_capture.sv
rtl/trace_arbiter.sv
rtl/trace_buffer.sv
rtl/commit_trace_top.sv
testbench/commit_trace_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the commit trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 -f sources.f --top-module commit_trace_tb -o commit_trace_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/commit_trace_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
   exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
   echo "No pass message found in $log"
   exit 1
fi
exit 0
